// File: zet_settings.svh
// --------------------
// zet core settings
// build-time sizes and the reset fetch address
// --------------------

`ifndef ZET_SETTINGS_SVH
`define ZET_SETTINGS_SVH

// word address width, wb_adr_o covers bits 19 to 1
`define ZET_ADDR_W 19

// prefetch queue entries, a power of two of at least 2
`define ZET_QUEUE_DEPTH 4

`define ZET_RESET_IP 0  // first word fetched after reset

`endif

// File: zet_pkg.sv
// --------------------
// zet core types
// words, addresses, instruction format and FSM states
// --------------------

`include "zet_settings.svh"

package zet_pkg;

  typedef logic [15:0] word_t;
  typedef logic [`ZET_ADDR_W-1:0] addr_t;  // word address
  typedef logic [1:0] reg_sel_t;

  typedef enum logic [3:0] {
    OP_NOP = 4'h0,
    OP_LDI = 4'h1,
    OP_ADD = 4'h2,
    OP_SUB = 4'h3,
    OP_XOR = 4'h4,
    OP_SHL = 4'h5,
    OP_OUT = 4'h6,
    OP_JMP = 4'h7,
    OP_JNZ = 4'h8,
    OP_HLT = 4'h9
  } opcode_e;

  // one instruction word, opcode in the top nibble
  typedef struct packed {
    opcode_e    opcode;
    reg_sel_t   rd;      // destination, also the JNZ test register
    reg_sel_t   rs;
    logic [7:0] imm;     // immediate or jump target
  } instr_t;

  typedef struct packed {
    logic  flush;  // one-cycle pulse
    addr_t target;
  } redirect_t;

  typedef enum logic [1:0] {FS_IDLE, FS_READ, FS_DRAIN} fetch_state_e;
  typedef enum logic {ES_RUN, ES_HALT} exec_state_e;

endpackage

// File: zet_fetch.sv
// --------------------
// zet fetch unit
// wishbone read master that keeps the prefetch queue filled
// --------------------

`include "zet_settings.svh"

module zet_fetch (
  input  logic                wb_clk_i,
  input  logic                reset_i,
  input  zet_pkg::word_t      wb_dat_i,
  input  logic                wb_ack_i,
  output zet_pkg::addr_t      wb_adr_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  input  logic                queue_full_i,
  output logic                push_o,
  output zet_pkg::instr_t     push_data_o,
  input  zet_pkg::redirect_t  redirect_i,
  input  logic                halted_i
);

  zet_pkg::fetch_state_e state_q;
  zet_pkg::fetch_state_e state_d;
  zet_pkg::addr_t        ip_q;   // next word to fetch
  zet_pkg::addr_t        adr_q;  // address of the read on the bus
  logic                  start_rd;

  // new read only from idle, with room in the queue and no redirect pending
  assign start_rd = (state_q == zet_pkg::FS_IDLE) && !queue_full_i && !halted_i &&
                    !redirect_i.flush;

  always_comb begin
    state_d = state_q;
    case (state_q)
      zet_pkg::FS_IDLE: begin
        if (start_rd) state_d = zet_pkg::FS_READ;
      end
      zet_pkg::FS_READ: begin
        if (wb_ack_i) state_d = zet_pkg::FS_IDLE;
        else if (redirect_i.flush) state_d = zet_pkg::FS_DRAIN;  // word now stale
      end
      zet_pkg::FS_DRAIN: begin
        if (wb_ack_i) state_d = zet_pkg::FS_IDLE;  // stale word dropped here
      end
      default: state_d = zet_pkg::FS_IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q <= zet_pkg::FS_IDLE;
      ip_q    <= zet_pkg::addr_t'(`ZET_RESET_IP);
    end else begin
      state_q <= state_d;
      if (redirect_i.flush) ip_q <= redirect_i.target;
      else if (push_o) ip_q <= ip_q + 1'b1;  // advance past the kept word
    end
  end

  // bus address latched at read start, held until the ack
  always_ff @(posedge wb_clk_i) begin
    if (start_rd) adr_q <= ip_q;
  end

  assign wb_adr_o = adr_q;
  assign wb_stb_o = (state_q != zet_pkg::FS_IDLE);
  assign wb_cyc_o = wb_stb_o;  // single reads, cyc follows stb

  // a word acked in the flush cycle is discarded
  assign push_o      = (state_q == zet_pkg::FS_READ) && wb_ack_i && !redirect_i.flush;
  assign push_data_o = zet_pkg::instr_t'(wb_dat_i);

endmodule

// File: zet_prefetch_queue.sv
// --------------------
// prefetch queue
// circular FIFO of instruction words with flush
// --------------------

`include "zet_settings.svh"

module zet_prefetch_queue (
  input  logic             wb_clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  zet_pkg::instr_t  push_data_i,
  input  logic             pop_i,
  input  logic             flush_i,
  output zet_pkg::instr_t  head_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int DEPTH = `ZET_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  zet_pkg::instr_t  mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !flush_i;  // flush wins over a same-cycle push
  assign do_pop  = pop_i && !empty_o && !flush_i;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // pointers wrap on their own
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));

endmodule

// File: zet_exec.sv
// --------------------
// zet execution unit
// decodes queued words, runs them on four registers
// --------------------

module zet_exec (
  input  logic                wb_clk_i,
  input  logic                reset_i,
  input  zet_pkg::instr_t     head_i,
  input  logic                empty_i,
  output logic                pop_o,
  output zet_pkg::redirect_t  redirect_o,
  output logic                out_stb_o,
  output zet_pkg::word_t      out_dat_o,
  output logic                halted_o
);

  zet_pkg::exec_state_e state_q;
  zet_pkg::word_t       regs_q [4];
  zet_pkg::word_t       rd_val;
  zet_pkg::word_t       rs_val;
  zet_pkg::word_t       result;
  zet_pkg::addr_t       target_q;
  logic                 wr_en;
  logic                 take_jump;
  logic                 flush_q;

  // the word behind a taken jump is still at the head during the flush
  assign pop_o = (state_q == zet_pkg::ES_RUN) && !empty_i && !flush_q;

  assign rd_val = regs_q[head_i.rd];
  assign rs_val = regs_q[head_i.rs];

  always_comb begin
    result    = rd_val;
    wr_en     = 1'b0;
    take_jump = 1'b0;
    case (head_i.opcode)
      zet_pkg::OP_LDI: begin
        result = zet_pkg::word_t'(head_i.imm);  // zero-extended
        wr_en  = 1'b1;
      end
      zet_pkg::OP_ADD: begin
        result = rd_val + rs_val;  // wraps mod 2^16
        wr_en  = 1'b1;
      end
      zet_pkg::OP_SUB: begin
        result = rd_val - rs_val;
        wr_en  = 1'b1;
      end
      zet_pkg::OP_XOR: begin
        result = rd_val ^ rs_val;
        wr_en  = 1'b1;
      end
      zet_pkg::OP_SHL: begin
        result = {rd_val[14:0], 1'b0};
        wr_en  = 1'b1;
      end
      zet_pkg::OP_JMP: take_jump = 1'b1;
      zet_pkg::OP_JNZ: take_jump = (rd_val != '0);
      default: ;  // OUT and HLT handled below, the rest are no-ops
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q   <= zet_pkg::ES_RUN;
      out_stb_o <= 1'b0;
      flush_q   <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      out_stb_o <= pop_o && (head_i.opcode == zet_pkg::OP_OUT);
      flush_q   <= pop_o && take_jump;
      if (pop_o && wr_en) regs_q[head_i.rd] <= result;
      // halt is sticky until reset
      if (pop_o && (head_i.opcode == zet_pkg::OP_HLT)) state_q <= zet_pkg::ES_HALT;
    end
  end

  // payload only, qualified by out_stb_o and flush_q
  always_ff @(posedge wb_clk_i) begin
    if (pop_o) begin
      out_dat_o <= rd_val;
      target_q  <= zet_pkg::addr_t'(head_i.imm);
    end
  end

  assign redirect_o.flush  = flush_q;
  assign redirect_o.target = target_q;
  assign halted_o          = (state_q == zet_pkg::ES_HALT);

endmodule

// File: zet_core.sv
// --------------------
// zet core top
// fetch, prefetch queue and exec on one wishbone port
// --------------------

module zet_core (
  // wishbone read master
  input  logic            wb_clk_i,
  input  logic            reset_i,
  input  zet_pkg::word_t  wb_dat_i,
  input  logic            wb_ack_i,
  output zet_pkg::addr_t  wb_adr_o,
  output logic            wb_cyc_o,
  output logic            wb_stb_o,
  // result port
  output logic            out_stb_o,
  output zet_pkg::word_t  out_dat_o,
  output logic            halted_o
);

  zet_pkg::instr_t    push_data;
  zet_pkg::instr_t    head;
  zet_pkg::redirect_t redirect;
  logic               push;
  logic               pop;
  logic               empty;
  logic               full;

  zet_fetch fetch (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .wb_adr_o     (wb_adr_o),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .queue_full_i (full),
    .push_o       (push),
    .push_data_o  (push_data),
    .redirect_i   (redirect),
    .halted_i     (halted_o)
  );

  zet_prefetch_queue queue (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .flush_i     (redirect.flush),
    .head_o      (head),
    .empty_o     (empty),
    .full_o      (full)
  );

  zet_exec exec (
    .wb_clk_i   (wb_clk_i),
    .reset_i    (reset_i),
    .head_i     (head),
    .empty_i    (empty),
    .pop_o      (pop),
    .redirect_o (redirect),
    .out_stb_o  (out_stb_o),
    .out_dat_o  (out_dat_o),
    .halted_o   (halted_o)
  );

endmodule

// File: tb_zet_mem.sv
// --------------------
// wishbone slave memory for the zet testbench
// 256 words, random wait states before each ack
// --------------------

module tb_zet_mem (
  input  logic            clk_i,
  input  logic            reset_i,
  input  zet_pkg::addr_t  adr_i,
  input  logic            cyc_i,
  input  logic            stb_i,
  output zet_pkg::word_t  dat_o,
  output logic            ack_o
);
  timeunit 1ns;
  timeprecision 1ps;

  zet_pkg::word_t mem_q [256];  // loaded by the testbench before reset ends
  integer         seed;
  int             wait_q;
  int             delay;
  logic           busy_q;

  initial begin
    seed  = 84261;
    ack_o = 1'b0;
    dat_o = '0;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      ack_o  <= 1'b0;
      busy_q <= 1'b0;
      wait_q <= 0;
    end else if (ack_o) begin
      ack_o  <= 1'b0;  // one ack per strobe
      busy_q <= 1'b0;
    end else if (cyc_i && stb_i) begin
      if (!busy_q) delay = $random(seed) & 3;  // 0 to 3 wait cycles
      else delay = wait_q;
      busy_q <= 1'b1;
      if (delay == 0) begin
        ack_o <= 1'b1;
        dat_o <= mem_q[adr_i[7:0]];
      end else begin
        wait_q <= delay - 1;
      end
    end
  end

endmodule

// File: tb_zet.sv
// --------------------
// zet core testbench
// runs a program against an instruction-set model
// --------------------

`include "zet_settings.svh"

module tb_zet;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_INSTR    = 300;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + MAX_INSTR * 5) * CLK_PERIOD;
  localparam int PROG_LEN     = 25;

  // nibbles are opcode, rd:rs, then the 8-bit immediate
  localparam logic [15:0] PROG [PROG_LEN] = '{
    16'h10C8, 16'h6000, 16'h1437, 16'h2100, 16'h6000,  // 0: ldi out ldi add out
    16'h3400, 16'h6400, 16'h4100, 16'h6000, 16'h5400,  // 5: sub out xor out shl
    16'h6400, 16'h5400, 16'h6400, 16'h7010, 16'h6000,  // 10: out shl out jmp 16, dead
    16'h6400, 16'h1805, 16'h1C01, 16'h6800, 16'h3B00,  // 15: dead, count loop setup
    16'h8812, 16'h6C00, 16'h9000, 16'h6000, 16'h6400   // 20: jnz 18, out, hlt, dead
  };

  logic           clk;
  logic           reset_i;
  zet_pkg::word_t wb_dat_i;
  logic           wb_ack_i;
  zet_pkg::addr_t wb_adr_o;
  logic           wb_cyc_o, wb_stb_o;
  logic           out_stb_o, halted_o;
  zet_pkg::word_t out_dat_o;

  zet_pkg::word_t expected_q [$];
  int             out_idx = 0;
  int             value_errs = 0;
  int             other_errs = 0;
  logic           reset_seen = 1'b0, first_read_seen = 1'b0;
  logic           halted_seen = 1'b0, bus_quiet = 1'b0;
  logic           prev_stb = 1'b0, prev_ack = 1'b0;
  zet_pkg::addr_t prev_adr = '0;
  int             after_reset = 0;

  zet_core dut_i (.*, .wb_clk_i(clk));

  tb_zet_mem wb_mem (.clk_i(clk), .reset_i(reset_i), .adr_i(wb_adr_o), .cyc_i(wb_cyc_o),
                     .stb_i(wb_stb_o), .dat_o(wb_dat_i), .ack_o(wb_ack_i));

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_value(string name, logic [31:0] exp_v, logic [31:0] got_v);
    $display("ERR %0t %s expected %0h got %0h", $time, name, exp_v, got_v);
    value_errs++;
  endtask

  task automatic report_failure(string msg);
    $display("at %0t: %s", $time, msg);
    other_errs++;
  endtask

  task automatic print_summary();
    $display("errors: %0d wrong values, %0d other failures, %0d of %0d out values seen",
             value_errs, other_errs, out_idx, expected_q.size());
  endtask

  // program words, unused space holds nops tagged with their address
  function automatic zet_pkg::word_t mem_word(int a);
    if (a < PROG_LEN) return PROG[a];
    return {8'h00, 8'(a)};
  endfunction

  // instruction-set model, collects the out values up to hlt
  task automatic run_model();
    zet_pkg::word_t  regs [4];
    zet_pkg::instr_t ins;
    int              pc;
    int              steps;
    logic            done;
    pc    = 0;
    steps = 0;
    done  = 1'b0;
    for (int i = 0; i < 4; i++) regs[i] = '0;
    while (!done && steps < MAX_INSTR) begin
      ins = zet_pkg::instr_t'(mem_word(pc % 256));
      pc++;
      steps++;
      case (ins.opcode)
        zet_pkg::OP_LDI: regs[ins.rd] = {8'h00, ins.imm};
        zet_pkg::OP_ADD: regs[ins.rd] = regs[ins.rd] + regs[ins.rs];
        zet_pkg::OP_SUB: regs[ins.rd] = regs[ins.rd] - regs[ins.rs];
        zet_pkg::OP_XOR: regs[ins.rd] = regs[ins.rd] ^ regs[ins.rs];
        zet_pkg::OP_SHL: regs[ins.rd] = regs[ins.rd] << 1;
        zet_pkg::OP_OUT: expected_q.push_back(regs[ins.rd]);
        zet_pkg::OP_JMP: pc = ins.imm;
        zet_pkg::OP_JNZ: if (regs[ins.rd] != '0) pc = ins.imm;
        zet_pkg::OP_HLT: done = 1'b1;
        default: ;
      endcase
    end
    if (!done) report_failure("reference model never reached HLT");
  endtask

  task automatic check_idle_outputs();
    assert (!wb_cyc_o) else report_value("wb_cyc_o", 0, wb_cyc_o);
    assert (!wb_stb_o) else report_value("wb_stb_o", 0, wb_stb_o);
    assert (!out_stb_o) else report_value("out_stb_o", 0, out_stb_o);
    assert (!halted_o) else report_value("halted_o", 0, halted_o);
  endtask

  // all checks sample the values settled before the edge
  always @(posedge clk) begin
    if (reset_i) begin
      if (reset_seen) check_idle_outputs();
      reset_seen  = 1'b1;
      after_reset = 0;
      prev_stb    = 1'b0;
    end else begin
      if (after_reset == 0) check_idle_outputs();  // first cycle out of reset
      after_reset++;
      assert (wb_cyc_o == wb_stb_o) else report_value("wb_cyc_o", wb_stb_o, wb_cyc_o);
      if (prev_stb && !prev_ack) begin  // read still waiting for its ack
        assert (wb_stb_o) else report_value("wb_stb_o", 1, wb_stb_o);
        assert (wb_adr_o == prev_adr) else report_value("wb_adr_o", prev_adr, wb_adr_o);
      end
      if (wb_stb_o && !first_read_seen) begin
        first_read_seen = 1'b1;
        assert (wb_adr_o == zet_pkg::addr_t'(`ZET_RESET_IP))
          else report_value("wb_adr_o", `ZET_RESET_IP, wb_adr_o);
      end
      if (out_stb_o) begin
        assert (!halted_o) else report_failure("out_stb_o pulsed after the core halted");
        assert (out_idx < expected_q.size())
          else report_failure("out_stb_o pulsed beyond the expected out list");
        if (out_idx < expected_q.size()) begin
          assert (out_dat_o == expected_q[out_idx])
            else report_value("out_dat_o", expected_q[out_idx], out_dat_o);
        end
        out_idx++;
      end
      if (halted_seen) assert (halted_o) else report_value("halted_o", 1, halted_o);
      if (halted_o) halted_seen = 1'b1;
      if (halted_seen && !wb_stb_o) bus_quiet = 1'b1;  // in-flight read done
      if (bus_quiet) assert (!wb_stb_o) else report_failure("a read started after HLT");
      prev_stb = wb_stb_o;
      prev_ack = wb_ack_i;
      prev_adr = wb_adr_o;
    end
  end

  initial begin
    reset_i = 1'b1;
    run_model();
    for (int a = 0; a < 256; a++) wb_mem.mem_q[a] = mem_word(a);
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
    wait (halted_o === 1'b1);
    repeat (20) @(posedge clk);  // watch the bus and out port stay quiet
    assert (out_idx == expected_q.size()) else report_failure("some out values never came");
    print_summary();
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired, the program did not halt");
    print_summary();
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
zet_pkg.sv
zet_fetch.sv
zet_prefetch_queue.sv
zet_exec.sv
zet_core.sv
tb_zet_mem.sv
tb_zet.sv

// File: run.sh
#!/bin/sh
# build the zet core testbench with verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_zet -o tb_zet
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_zet > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
